// ==== design/cdda_pkg.sv ====
package cdda_pkg;

	// one CD-DA sector is 2352 bytes, four bytes per word
	localparam int SECTOR_WORDS = 2352 / 4;

	// ring holds two sectors, rounded up to a power of two
	localparam int BUFFER_WIDTH = $clog2(2 * SECTOR_WORDS);
	localparam int BUFFER_WORDS = 2 ** BUFFER_WIDTH;

	localparam int SAMPLE_RATE = 44100; // Hz

	// one stereo pair as it comes from the drive
	// raw on the write side and in the ring, stereo from the read side on
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic signed [15:0] right; // high half
			logic signed [15:0] left;  // low half
		} stereo;
	} cdda_word_t;

endpackage

// ==== design/cdc_vector_handshake_continuous.sv ====
`timescale 1ns/1ps

module cdc_vector_handshake_continuous #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk_in,
	input  logic                  clk_out,
	input  logic                  rst,
	input  logic [DATA_WIDTH-1:0] data_in,
	output logic [DATA_WIDTH-1:0] data_out
);

	logic rst_in_s1;
	logic rst_in;
	logic rst_out_s1;
	logic rst_out;

	// sending side
	logic [DATA_WIDTH-1:0] data_hold;
	logic req_tgl;
	logic ack_s1;
	logic ack_s2;
	logic take_new;

	// receiving side
	logic req_s1;
	logic req_s2;
	logic ack_tgl;

	// local copy of the reset in each domain
	always_ff @(posedge clk_in) begin
		rst_in_s1 <= rst;
		rst_in    <= rst_in_s1;
	end

	always_ff @(posedge clk_out) begin
		rst_out_s1 <= rst;
		rst_out    <= rst_out_s1;
	end

	// last value has been taken over, free to grab the next one
	assign take_new = (req_tgl == ack_s2);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			req_tgl <= 1'b0;
			ack_s1  <= 1'b0;
			ack_s2  <= 1'b0;
		end else begin
			ack_s1 <= ack_tgl;
			ack_s2 <= ack_s1;
			if (take_new)
				req_tgl <= ~req_tgl;
		end
	end

	// stays stable while the request is in flight
	always_ff @(posedge clk_in) begin
		if (take_new)
			data_hold <= data_in;
	end

	always_ff @(posedge clk_out) begin
		if (rst_out) begin
			req_s1   <= 1'b0;
			req_s2   <= 1'b0;
			ack_tgl  <= 1'b0;
			data_out <= '0;
		end else begin
			req_s1 <= req_tgl;
			req_s2 <= req_s1;
			if (req_s2 != ack_tgl) begin
				data_out <= data_hold;
				ack_tgl  <= req_s2; // hand back to sender
			end
		end
	end

endmodule

// ==== design/cdda_sample_buffer.sv ====
`timescale 1ns/1ps

module cdda_sample_buffer (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 wr,
	input  cdda_pkg::cdda_word_t wr_data,
	input  logic                 sample_clk,
	output cdda_pkg::cdda_word_t pair,
	output logic                 req
);

	localparam int AW = cdda_pkg::BUFFER_WIDTH;
	localparam int CW = cdda_pkg::BUFFER_WIDTH + 1;
	localparam logic [CW-1:0] RING_SIZE   = CW'(cdda_pkg::BUFFER_WORDS);
	localparam logic [CW-1:0] SECTOR_SIZE = CW'(cdda_pkg::SECTOR_WORDS);

	logic [31:0] mem [cdda_pkg::BUFFER_WORDS];
	cdda_pkg::cdda_word_t wr_word;
	cdda_pkg::cdda_word_t rd_word;

	logic [AW-1:0] write_addr;
	logic [AW-1:0] read_addr;
	logic [CW-1:0] fill_cnt;

	logic wr_d;
	logic wr_edge;
	logic wr_req;
	logic ring_full;
	logic ring_empty;

	logic smp_d1;
	logic smp_d2;
	logic smp_filt;
	logic tick;
	logic rd_done;

	assign wr_edge    = wr & ~wr_d;
	assign ring_full  = AW'(write_addr + 1'b1) == read_addr; // one slot kept free
	assign ring_empty = (read_addr == write_addr);

	// falling edge of the filtered sample clock
	assign tick = (smp_d1 == smp_d2) & smp_filt & ~smp_d2;

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_d       <= 1'b0;
			wr_req     <= 1'b0;
			write_addr <= '0;
		end else begin
			wr_d   <= wr;
			wr_req <= wr_edge & ~ring_full; // dropped when full
			if (wr_req)
				write_addr <= write_addr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_edge)
			wr_word <= wr_data;
	end

	always_ff @(posedge CLK) begin
		if (wr_req)
			mem[write_addr] <= wr_word.raw;
	end

	// registered read, a store to the read address is forwarded
	always_ff @(posedge CLK) begin
		if (wr_req && write_addr == read_addr)
			rd_word.raw <= wr_word.raw;
		else
			rd_word.raw <= mem[read_addr];
	end

	// sample clock comes from the audio domain
	always_ff @(posedge CLK) begin
		if (rst) begin
			smp_d1   <= 1'b0;
			smp_d2   <= 1'b0;
			smp_filt <= 1'b0;
		end else begin
			smp_d1 <= sample_clk;
			smp_d2 <= smp_d1;
			if (smp_d1 == smp_d2)
				smp_filt <= smp_d2;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			read_addr <= '0;
			rd_done   <= 1'b0;
			pair.raw  <= '0;
		end else begin
			rd_done <= 1'b0;
			if (tick) begin
				if (ring_empty) begin
					pair.stereo.left  <= '0; // underrun, play silence
					pair.stereo.right <= '0;
				end else begin
					pair.stereo.left  <= rd_word.stereo.left;
					pair.stereo.right <= rd_word.stereo.right;
					read_addr         <= read_addr + 1'b1;
					rd_done           <= 1'b1;
				end
			end
		end
	end

	// fill level and data request to the drive
	always_ff @(posedge CLK) begin
		if (rst) begin
			fill_cnt <= '0;
			req      <= 1'b1;
		end else begin
			fill_cnt <= fill_cnt + CW'(wr_req) - CW'(rd_done);
			req      <= (RING_SIZE - fill_cnt) >= SECTOR_SIZE; // a whole sector fits
		end
	end

endmodule

// ==== design/cdda_audio_out.sv ====
`timescale 1ns/1ps

module cdda_audio_out #(
	parameter int CLK_AUDIO_RATE = 24_576_000
) (
	input  logic                 CLK_AUDIO,
	input  logic                 rst,
	input  cdda_pkg::cdda_word_t pair_audio,
	input  logic [3:0]           volume_l,
	input  logic [3:0]           volume_r,
	output logic                 sample_clk,
	output logic                 audio_ce,
	output logic signed [15:0]   audio_l,
	output logic signed [15:0]   audio_r
);

	// sample_clk toggles, so step by twice the sample rate
	localparam logic [31:0] ACC_STEP = 32'(2 * cdda_pkg::SAMPLE_RATE);
	localparam logic [31:0] ACC_WRAP = 32'(CLK_AUDIO_RATE);

	logic [31:0] acc;
	logic [31:0] acc_next;
	logic        sample_clk_d;
	logic        sample_rise;
	logic [3:0]  shift_l;
	logic [3:0]  shift_r;

	assign acc_next    = acc + ACC_STEP;
	assign sample_rise = sample_clk & ~sample_clk_d;

	// volume 15 passes the sample unchanged
	assign shift_l = 4'd15 - volume_l;
	assign shift_r = 4'd15 - volume_r;

	always_ff @(posedge CLK_AUDIO) begin
		if (rst) begin
			acc        <= '0;
			sample_clk <= 1'b0;
		end else if (acc_next >= ACC_WRAP) begin
			acc        <= acc_next - ACC_WRAP;
			sample_clk <= ~sample_clk;
		end else begin
			acc <= acc_next;
		end
	end

	always_ff @(posedge CLK_AUDIO) begin
		if (rst) begin
			sample_clk_d <= 1'b0;
			audio_ce     <= 1'b0;
		end else begin
			sample_clk_d <= sample_clk;
			audio_ce     <= sample_rise; // one cycle per sample
		end
	end

	// held until the next sample
	always_ff @(posedge CLK_AUDIO) begin
		if (sample_rise) begin
			audio_l <= pair_audio.stereo.left >>> shift_l;
			audio_r <= pair_audio.stereo.right >>> shift_r;
		end
	end

endmodule

// ==== design/cdda.sv ====
`timescale 1ns/1ps

module cdda #(
	parameter int CLK_AUDIO_RATE = 24_576_000
) (
	input  logic        CLK,
	input  logic        rst,
	input  logic        CLK_AUDIO,
	input  logic        CDDA_WR,
	input  logic [31:0] CDDA_DATA,
	input  logic [3:0]  VOLUME_L,
	input  logic [3:0]  VOLUME_R,
	output logic        CDDA_REQ,
	output logic        AUDIO_CE,
	output logic [15:0] AUDIO_L,
	output logic [15:0] AUDIO_R
);

	cdda_pkg::cdda_word_t pair;       // CLK domain
	cdda_pkg::cdda_word_t pair_audio; // CLK_AUDIO domain
	logic                 sample_clk;

	cdda_sample_buffer u_buffer (
		.CLK        (CLK),
		.rst        (rst),
		.wr         (CDDA_WR),
		.wr_data    (CDDA_DATA),
		.sample_clk (sample_clk),
		.pair       (pair),
		.req        (CDDA_REQ)
	);

	// pair changes once per sample period, far slower than the handshake
	cdc_vector_handshake_continuous #(
		.DATA_WIDTH (32)
	) u_pair_cdc (
		.clk_in   (CLK),
		.clk_out  (CLK_AUDIO),
		.rst      (rst),
		.data_in  (pair),
		.data_out (pair_audio)
	);

	cdda_audio_out #(
		.CLK_AUDIO_RATE (CLK_AUDIO_RATE)
	) u_audio_out (
		.CLK_AUDIO  (CLK_AUDIO),
		.rst        (rst),
		.pair_audio (pair_audio),
		.volume_l   (VOLUME_L),
		.volume_r   (VOLUME_R),
		.sample_clk (sample_clk),
		.audio_ce   (AUDIO_CE),
		.audio_l    (AUDIO_L),
		.audio_r    (AUDIO_R)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk; // 50% duty
	end

endmodule

// ==== tests/cdda_props.sv ====
`timescale 1ns/1ps

module cdda_props (
	input logic                              clk,
	input logic                              rst,
	input logic                              ce,
	input logic [cdda_pkg::BUFFER_WIDTH:0]   fill_cnt,
	input logic [cdda_pkg::BUFFER_WIDTH-1:0] write_addr,
	input logic [cdda_pkg::BUFFER_WIDTH-1:0] read_addr,
	input logic                              req
);

	localparam int FULL_FILL = cdda_pkg::BUFFER_WORDS - 1;

	logic [cdda_pkg::BUFFER_WIDTH-1:0] ptr_fill;
	logic sector_free;

	assign ptr_fill    = write_addr - read_addr; // wraps with the ring
	assign sector_free = (cdda_pkg::BUFFER_WORDS - int'(ptr_fill)) >= cdda_pkg::SECTOR_WORDS;

	// output enable is a single-cycle pulse
	ce_single: assert property (@(posedge clk) disable iff (rst) ce |=> !ce)
		else $error("audio_ce stayed high for two cycles");

	fill_limit: assert property (@(posedge clk) disable iff (rst) int'(fill_cnt) <= FULL_FILL)
		else $error("fill count %0d beyond the ring limit", fill_cnt);

	// pointer fill never runs ahead of the fill count
	req_off: assert property (@(posedge clk) disable iff (rst) !sector_free |=> !req)
		else $error("req high with less than a sector free");

endmodule

// ==== tests/cdda_tb.sv ====
`timescale 1ns/1ps

module cdda_tb;

	localparam int CLK_AUDIO_RATE = 32 * cdda_pkg::SAMPLE_RATE;
	localparam int SAMPLE_CLKS    = 48; // 32 audio cycles of 6 ns in 4 ns CLK cycles
	localparam int BURST          = 16;
	localparam int WINDOW_WRITES  = 6;
	localparam int OVER_WINDOWS   = 12;
	localparam int TOTAL_WRITES   = 4 * BURST + 2 * cdda_pkg::BUFFER_WORDS
		+ OVER_WINDOWS * WINDOW_WRITES;
	localparam int MAX_CYCLES     = 2 * (TOTAL_WRITES + 40) * SAMPLE_CLKS;
	localparam int REQ_LOW_AT     = cdda_pkg::BUFFER_WORDS - cdda_pkg::SECTOR_WORDS + 1;
	localparam int REQ_SLACK      = 3;

	logic        CLK;
	logic        CLK_AUDIO;
	logic        rst;
	logic        CDDA_WR;
	logic [31:0] CDDA_DATA;
	logic [3:0]  VOLUME_L;
	logic [3:0]  VOLUME_R;
	logic        CDDA_REQ;
	logic        AUDIO_CE;
	logic [15:0] AUDIO_L;
	logic [15:0] AUDIO_R;

	logic [31:0] written_q[$]; // accepted pairs in write order
	int          accepted = 0;
	int          dropped = 0;
	int          check_errors = 0;
	int          played = 0;
	int          silences = 0;
	int          ce_count = 0;
	int          output_errors = 0;
	int          cycles = 0;
	logic        req_seen_low = 1'b0;
	string       test_name = "reset";

	tb_clock #(.PERIOD_NS(4.0)) clk_gen (.clk(CLK));
	tb_clock #(.PERIOD_NS(6.0)) audio_clk_gen (.clk(CLK_AUDIO));

	cdda #(
		.CLK_AUDIO_RATE (CLK_AUDIO_RATE)
	) DUT (
		.CLK       (CLK),
		.rst       (rst),
		.CLK_AUDIO (CLK_AUDIO),
		.CDDA_WR   (CDDA_WR),
		.CDDA_DATA (CDDA_DATA),
		.VOLUME_L  (VOLUME_L),
		.VOLUME_R  (VOLUME_R),
		.CDDA_REQ  (CDDA_REQ),
		.AUDIO_CE  (AUDIO_CE),
		.AUDIO_L   (AUDIO_L),
		.AUDIO_R   (AUDIO_R)
	);

	bind cdda_sample_buffer cdda_props buffer_props (
		.clk        (CLK),
		.rst        (rst),
		.ce         (1'b0),
		.fill_cnt   (fill_cnt),
		.write_addr (write_addr),
		.read_addr  (read_addr),
		.req        (req)
	);

	bind cdda_audio_out cdda_props output_props (
		.clk        (CLK_AUDIO),
		.rst        (rst),
		.ce         (audio_ce),
		.fill_cnt   ('0),
		.write_addr ('0),
		.read_addr  ('0),
		.req        (1'b0)
	);

	// arithmetic shift done as floor division by a power of two
	function automatic logic [15:0] scale_sample(input logic [15:0] sample,
		input logic [3:0] volume);
		int value;
		int divisor;
		int quot;
		value   = int'($signed(sample));
		divisor = 1 << (15 - int'(volume));
		quot    = value / divisor;
		if (value < 0 && quot * divisor != value)
			quot = quot - 1; // round toward minus infinity
		return quot[15:0];
	endfunction

	// top nibble never 0 or F, so no volume used here scales it to zero
	function automatic logic [15:0] random_sample();
		logic [3:0] top;
		top = 4'(1 + ($urandom % 14));
		return {top, 12'($urandom)};
	endfunction

	task automatic write_pair(input logic [31:0] word);
		if (accepted - played < cdda_pkg::BUFFER_WORDS - 1) begin
			written_q.push_back(word);
			accepted++;
		end else begin
			dropped++;
		end
		CDDA_DATA = word;
		CDDA_WR   = 1'b1;
		@(negedge CLK);
		CDDA_WR = 1'b0;
		@(negedge CLK);
	endtask

	task automatic write_burst(input int count);
		repeat (count) write_pair({random_sample(), random_sample()});
	endtask

	task automatic wait_samples(input int count);
		int start;
		start = ce_count;
		while (ce_count < start + count)
			@(negedge CLK);
	endtask

	// all pending pairs played, then two silent outputs
	task automatic drain_queue();
		int start;
		while (written_q.size() != played)
			@(negedge CLK);
		start = silences;
		while (silences < start + 2)
			@(negedge CLK);
	endtask

	task automatic check_req();
		int occ;
		occ = accepted - played;
		if (occ >= REQ_LOW_AT + REQ_SLACK && CDDA_REQ !== 1'b0) begin
			check_errors++;
			$display("MISMATCH %s CDDA_REQ at occupancy %0d: expected %b, actual %b",
				test_name, occ, 1'b0, CDDA_REQ);
		end
		if (occ < REQ_LOW_AT - REQ_SLACK && CDDA_REQ !== 1'b1) begin
			check_errors++;
			$display("MISMATCH %s CDDA_REQ at occupancy %0d: expected %b, actual %b",
				test_name, occ, 1'b1, CDDA_REQ);
		end
		if (CDDA_REQ === 1'b0)
			req_seen_low = 1'b1;
	endtask

	always @(negedge CLK_AUDIO) begin : compare_output
		logic [31:0] want;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		if (!rst && AUDIO_CE === 1'b1) begin
			ce_count = ce_count + 1;
			if (AUDIO_L === 16'h0000 && AUDIO_R === 16'h0000) begin
				silences = silences + 1;
			end else if (written_q.size() <= played) begin
				output_errors = output_errors + 1;
				$display("ERROR: %s: output %h/%h appeared with no pending write",
					test_name, AUDIO_L, AUDIO_R);
			end else begin
				want   = written_q[played];
				played = played + 1;
				exp_l  = scale_sample(want[15:0], VOLUME_L);  // left in the low half
				exp_r  = scale_sample(want[31:16], VOLUME_R);
				if (AUDIO_L !== exp_l) begin
					output_errors = output_errors + 1;
					$display("MISMATCH %s left: expected %h, actual %h",
						test_name, exp_l, AUDIO_L);
				end
				if (AUDIO_R !== exp_r) begin
					output_errors = output_errors + 1;
					$display("MISMATCH %s right: expected %h, actual %h",
						test_name, exp_r, AUDIO_R);
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("ERROR: timeout after %0d cycles in test %s", cycles, test_name);
			$display("errors: %0d, writes accepted %0d, dropped %0d, samples played %0d",
				check_errors + output_errors + 1, accepted, dropped, played);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin : stimulus
		int unsigned seed_ret;
		seed_ret  = $urandom(32'h302b);
		rst       = 1'b1;
		CDDA_WR   = 1'b0;
		CDDA_DATA = 32'h0;
		VOLUME_L  = 4'd15;
		VOLUME_R  = 4'd15;
		repeat (8) @(negedge CLK);
		rst = 1'b0;
		@(negedge CLK);

		test_name = "idle";
		if (CDDA_REQ !== 1'b1) begin
			check_errors++;
			$display("ERROR: idle: CDDA_REQ is not high with an empty ring");
		end
		if (AUDIO_CE !== 1'b0) begin
			check_errors++;
			$display("ERROR: idle: AUDIO_CE is not low after reset");
		end
		wait_samples(4);

		test_name = "burst_full_volume";
		write_burst(BURST);
		drain_queue();

		test_name = "per_channel_volume";
		VOLUME_L = 4'd12;
		VOLUME_R = 4'd5;
		write_burst(BURST);
		drain_queue();
		VOLUME_L = 4'd15;
		VOLUME_R = 4'd15;

		// back to back writes while every one is surely stored
		test_name = "fill_req";
		while (accepted - played < cdda_pkg::BUFFER_WORDS - 1) begin
			check_req();
			write_pair({random_sample(), random_sample()});
		end
		if (!req_seen_low) begin
			check_errors++;
			$display("ERROR: fill_req: CDDA_REQ never went low while the ring filled");
		end

		// right after an output no pair is in flight, ring fill equals the model
		test_name = "overflow";
		repeat (OVER_WINDOWS) begin
			wait_samples(1);
			write_burst(WINDOW_WRITES);
		end

		test_name = "drain_req";
		while (written_q.size() != played) begin
			check_req();
			@(negedge CLK);
		end
		drain_queue();
		if (CDDA_REQ !== 1'b1) begin
			check_errors++;
			$display("ERROR: drain_req: CDDA_REQ did not rise after the ring emptied");
		end

		test_name = "underrun_resume";
		write_burst(BURST);
		drain_queue();
		write_burst(BURST);
		drain_queue();

		repeat (4) @(negedge CLK);
		$display("errors: %0d, writes accepted %0d, dropped %0d, samples played %0d",
			check_errors + output_errors, accepted, dropped, played);
		if (check_errors + output_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/cdda_pkg.sv
design/cdc_vector_handshake_continuous.sv
design/cdda_sample_buffer.sv
design/cdda_audio_out.sv
design/cdda.sv
tests/tb_clock.sv
tests/cdda_props.sv
tests/cdda_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cdda_tb -f filelist.f -o cdda_sim \
	&& ./obj_dir/cdda_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
